// ==== eth_rx_top.f ====
+incdir+src
src/eth_rx_pkg.sv
src/rx_header_filter.sv
src/rx_length_checker.sv
src/rx_tail_trimmer.sv
src/eth_rx_top.sv
tests/rx_scoreboard.sv
tests/tb_eth_rx_top.sv

// ==== tests/tb_eth_rx_top.sv ====
`default_nettype none

`include "eth_rx_defs.svh"

module tb_eth_rx_top
  import eth_rx_pkg::*;
();

  // header fields as the packet builder sees them
  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] eth_type;
    logic [3:0]  version;
    logic [7:0]  proto;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] udp_len;
  } hdr_t;

  logic        rx_axis_aclk = 1'b0;
  logic        rx_axis_aresetn;
  rx_config_t  cfg;
  rx_beat_t    mac_beat;
  rx_beat_t    udp_beat;
  rx_status_t  status;
  int          pending;
  int          error_count;
  int          timeouts = 0;
  logic [31:0] rng = 32'd17;
  logic [7:0]  frame_q[$];

  always #5 rx_axis_aclk = ~rx_axis_aclk;

  eth_rx_top i_dut (
    .rx_axis_aclk    (rx_axis_aclk),
    .rx_axis_aresetn (rx_axis_aresetn),
    .cfg             (cfg),
    .mac_beat        (mac_beat),
    .udp_beat        (udp_beat),
    .status          (status)
  );

  rx_scoreboard i_scoreboard (
    .rx_axis_aclk    (rx_axis_aclk),
    .rx_axis_aresetn (rx_axis_aresetn),
    .cfg             (cfg),
    .mac_beat        (mac_beat),
    .udp_beat        (udp_beat),
    .status          (status),
    .pending         (pending),
    .error_count     (error_count)
  );

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift32(rng);
    r = rng;
  endtask

  task automatic push_bytes(input logic [47:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      frame_q.push_back(v[8*i +: 8]);
    end
  endtask

  // header that matches the current cfg
  task automatic good_header(input int payload_len, output hdr_t h);
    logic [31:0] r;
    next_rand(r);
    h.dst_mac  = cfg.dst_mac;
    h.src_mac  = cfg.src_mac;
    h.eth_type = eth_type_ipv4;
    h.version  = `RX_IP_VERSION;
    h.proto    = ip_proto_udp;
    h.src_ip   = r;
    h.dst_ip   = cfg.dst_ip;
    h.src_port = r[31:16];
    h.dst_port = cfg.dst_port;
    h.udp_len  = 16'(payload_len + `RX_UDP_HDR_BYTES);
  endtask

  function automatic hdr_t swap_addresses(input hdr_t h);
    hdr_t s;
    s          = h;
    s.dst_mac  = h.src_mac;
    s.src_mac  = h.dst_mac;
    s.dst_ip   = h.src_ip;
    s.src_ip   = h.dst_ip;
    s.dst_port = h.src_port;
    s.src_port = h.dst_port;
    return s;
  endfunction

  task automatic send_packet(input hdr_t h, input int payload_len, input logic empty_tail);
    logic [31:0] r;
    rx_beat_t    b;
    int          n_beats;
    frame_q.delete();
    push_bytes(h.dst_mac, 6);
    push_bytes(h.src_mac, 6);
    push_bytes(h.eth_type, 2);
    push_bytes({h.version, 4'd5}, 1);
    push_bytes(0, 1);
    push_bytes(28 + payload_len, 2);
    push_bytes(0, 4);
    push_bytes(64, 1);
    push_bytes(h.proto, 1);
    push_bytes(0, 2);
    push_bytes(h.src_ip, 4);
    push_bytes(h.dst_ip, 4);
    push_bytes(h.src_port, 2);
    push_bytes(h.dst_port, 2);
    push_bytes(h.udp_len, 2);
    push_bytes(0, 2);
    for (int i = 0; i < payload_len; i++) begin
      next_rand(r);
      push_bytes(r[7:0], 1);
    end
    n_beats = (frame_q.size() + `RX_DATA_BYTES - 1) / `RX_DATA_BYTES;
    for (int bi = 0; bi < n_beats; bi++) begin
      b = '0;
      b.valid = 1'b1;
      for (int li = 0; li < `RX_DATA_BYTES; li++) begin
        if (bi * `RX_DATA_BYTES + li < frame_q.size()) begin
          b.data[8*li +: 8] = frame_q[bi*`RX_DATA_BYTES+li];
          b.keep[li] = 1'b1;
        end
      end
      b.last = (bi == n_beats - 1) && !empty_tail;
      @(posedge rx_axis_aclk);
      mac_beat <= b;
    end
    if (empty_tail) begin
      b = '0;
      b.valid = 1'b1;
      b.last = 1'b1;
      @(posedge rx_axis_aclk);
      mac_beat <= b;
    end
    @(posedge rx_axis_aclk);
    mac_beat <= '0;
  endtask

  // waits until every expected beat and status has been seen
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge rx_axis_aclk);
    while (pending != 0 && waited < 100) begin
      @(negedge rx_axis_aclk);
      waited++;
    end
    if (pending != 0) begin
      $display("Timeout: DUT output still outstanding after %0d cycles", waited);
      timeouts++;
    end
    // time for a stray strobe from a dropped packet to show up
    repeat (4) @(posedge rx_axis_aclk);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : stimulus
    hdr_t        h;
    logic [31:0] r;
    int          len;
    rx_axis_aresetn = 1'b0;
    mac_beat        = '0;
    cfg.dst_mac     = 48'h02_00_00_00_00_0a;
    cfg.src_mac     = 48'h02_00_00_00_00_b0;
    cfg.dst_ip      = 32'hc0_a8_01_0a;
    cfg.dst_port    = 16'd4791;
    cfg.loopback    = 1'b0;
    repeat (16) @(posedge rx_axis_aclk);
    rx_axis_aresetn <= 1'b1;

    i_scoreboard.start_test("reset_idle");
    repeat (8) @(posedge rx_axis_aclk);

    i_scoreboard.start_test("random_accept");
    repeat (6) begin
      next_rand(r);
      len = r % 200;
      good_header(len, h);
      send_packet(h, len, 1'b0);
      wait_drain();
    end

    i_scoreboard.start_test("single_field_drop");
    for (int f = 0; f < 7; f++) begin
      good_header(20, h);
      case (f)
        0: h.dst_mac = h.dst_mac ^ 48'd1;
        1: h.src_mac = h.src_mac ^ 48'h100;
        2: h.eth_type = 16'h86dd;
        3: h.version = 4'd6;
        4: h.proto = 8'd6;
        5: h.dst_ip = h.dst_ip ^ 32'd8;
        default: h.dst_port = h.dst_port ^ 16'd1;
      endcase
      send_packet(h, 20, 1'b0);
      wait_drain();
    end

    i_scoreboard.start_test("length_field");
    good_header(37, h);
    send_packet(h, 37, 1'b0);
    wait_drain();
    h.udp_len = h.udp_len + 16'd5;
    send_packet(h, 37, 1'b0);
    wait_drain();

    i_scoreboard.start_test("empty_tail");
    good_header(100, h);
    send_packet(h, 100, 1'b1);
    wait_drain();

    i_scoreboard.start_test("loopback");
    cfg.loopback <= 1'b1;
    good_header(64, h);
    send_packet(swap_addresses(h), 64, 1'b0);
    wait_drain();
    send_packet(h, 64, 1'b0);
    wait_drain();
    cfg.loopback <= 1'b0;

    // let the compare process finish the last edge first
    @(negedge rx_axis_aclk);
    i_scoreboard.print_summary(timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/rx_scoreboard.sv ====
`default_nettype none

`include "eth_rx_defs.svh"

module rx_scoreboard
  import eth_rx_pkg::*;
(
  input  logic       rx_axis_aclk,
  input  logic       rx_axis_aresetn,
  input  rx_config_t cfg,
  input  rx_beat_t   mac_beat,
  input  rx_beat_t   udp_beat,
  input  rx_status_t status,
  output int         pending,
  output int         error_count
);

  typedef struct packed {
    logic [31:0] cycle;
    rx_beat_t    beat;
  } exp_beat_t;

  typedef struct packed {
    logic [31:0] cycle;
    rx_status_t  result;
  } exp_status_t;

  exp_beat_t   beat_q[$];
  exp_status_t status_q[$];
  string       test_name = "none";
  int          cycle = 0;
  int          value_errors = 0;
  int          event_errors = 0;
  // packet state of the input monitor
  logic        in_pkt = 1'b0;
  logic        accepted = 1'b0;
  int          frame_bytes = 0;
  logic [15:0] udp_len = '0;

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // n bytes from offset ofs, first wire byte in the msb
  function automatic logic [47:0] net_field(input logic [`RX_DATA_WIDTH-1:0] d,
                                            input int ofs, input int n);
    logic [47:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[39:0], d[8*(ofs+i) +: 8]};
    end
    return v;
  endfunction

  function automatic logic header_accepted(input logic [`RX_DATA_WIDTH-1:0] d,
                                           input rx_config_t c);
    int dmac;
    int smac;
    int dip;
    int dport;
    // loopback frames carry our addresses in the source fields
    dmac  = c.loopback ? 6 : 0;
    smac  = c.loopback ? 0 : 6;
    dip   = c.loopback ? 26 : 30;
    dport = c.loopback ? 34 : 36;
    return net_field(d, dmac, 6) == c.dst_mac &&
           net_field(d, smac, 6) == c.src_mac &&
           net_field(d, 12, 2) == `RX_ETHTYPE_IPV4 &&
           d[8*14+4 +: 4] == `RX_IP_VERSION &&
           net_field(d, 23, 1) == `RX_IP_PROTO_UDP &&
           net_field(d, dip, 4) == c.dst_ip &&
           net_field(d, dport, 2) == c.dst_port;
  endfunction

  function automatic rx_status_t length_status(input int bytes, input logic [15:0] len_field);
    rx_status_t s;
    s.valid        = 1'b1;
    s.measured_len = 16'(bytes - `RX_HDR_BYTES);
    s.expected_len = len_field - 16'(`RX_UDP_HDR_BYTES);
    s.length_ok    = (s.measured_len == s.expected_len);
    return s;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
  endtask

  task automatic check_value(input string what, input logic [511:0] expected,
                             input logic [511:0] actual);
    if (actual !== expected) begin
      $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what,
               expected, actual);
      value_errors++;
    end
  endtask

  task automatic print_summary(input int timeouts);
    $display("errors: %0d wrong values, %0d missing or extra strobes, %0d timeouts",
             value_errors, event_errors, timeouts);
  endtask

  // ----------------------------------------
  // input monitor
  // ----------------------------------------
  always @(posedge rx_axis_aclk) begin : monitor
    exp_beat_t eb;
    if (rx_axis_aresetn && mac_beat.valid) begin
      if (!in_pkt) begin
        accepted    = header_accepted(mac_beat.data, cfg);
        udp_len     = 16'(net_field(mac_beat.data, 38, 2));
        frame_bytes = 0;
      end
      in_pkt      = !mac_beat.last;
      frame_bytes = frame_bytes + $countones(mac_beat.keep);
      if (accepted && mac_beat.keep != '0) begin
        eb.cycle = 32'(cycle + 2);
        eb.beat  = mac_beat;
        beat_q.push_back(eb);
      end else if (accepted && mac_beat.last && beat_q.size() != 0) begin
        // empty closing beat, last moves to the beat ahead
        eb = beat_q.pop_back();
        eb.beat.last = 1'b1;
        beat_q.push_back(eb);
      end
      if (accepted && mac_beat.last) begin
        status_q.push_back(exp_status_t'({32'(cycle + 2), length_status(frame_bytes, udp_len)}));
      end
    end
    pending = beat_q.size() + status_q.size();
  end

  // ----------------------------------------
  // output compare
  // ----------------------------------------
  always @(posedge rx_axis_aclk) begin : compare
    exp_beat_t   eb;
    exp_status_t es;
    cycle <= cycle + 1;
    if (rx_axis_aresetn) begin
      if (udp_beat.valid === 1'b1 && beat_q.size() != 0) begin
        eb = beat_q.pop_front();
        check_value("udp_beat cycle", eb.cycle, cycle);
        check_value("udp_beat.data", eb.beat.data, udp_beat.data);
        check_value("udp_beat.keep", eb.beat.keep, udp_beat.keep);
        check_value("udp_beat.last", eb.beat.last, udp_beat.last);
      end else if (udp_beat.valid !== 1'b0) begin
        $display("[%s] udp_beat.valid was %b at cycle %0d but no beat was due",
                 test_name, udp_beat.valid, cycle);
        event_errors++;
      end else if (beat_q.size() != 0 && beat_q[0].cycle <= cycle) begin
        $display("[%s] expected output beat never appeared by cycle %0d", test_name, cycle);
        eb = beat_q.pop_front();
        event_errors++;
      end
      if (status.valid === 1'b1 && status_q.size() != 0) begin
        es = status_q.pop_front();
        check_value("status cycle", es.cycle, cycle);
        check_value("status.length_ok", es.result.length_ok, status.length_ok);
        check_value("status.expected_len", es.result.expected_len, status.expected_len);
        check_value("status.measured_len", es.result.measured_len, status.measured_len);
      end else if (status.valid !== 1'b0) begin
        $display("[%s] status.valid was %b at cycle %0d but no status was due",
                 test_name, status.valid, cycle);
        event_errors++;
      end else if (status_q.size() != 0 && status_q[0].cycle <= cycle) begin
        $display("[%s] expected status strobe never appeared by cycle %0d", test_name, cycle);
        es = status_q.pop_front();
        event_errors++;
      end
    end
    pending     = beat_q.size() + status_q.size();
    error_count = value_errors + event_errors;
  end

endmodule

`default_nettype wire

// ==== src/eth_rx_top.sv ====
`default_nettype none

`include "eth_rx_defs.svh"

module eth_rx_top
  import eth_rx_pkg::*;
(
  input  logic       rx_axis_aclk,
  input  logic       rx_axis_aresetn,

  // runtime configuration
  input  rx_config_t cfg,

  // from the mac
  input  rx_beat_t   mac_beat,

  // to the user side
  output rx_beat_t   udp_beat,
  output rx_status_t status
);

  // ----------------------------------------
  // stage wires
  // ----------------------------------------
  rx_beat_t                 filt_beat;
  logic [`RX_LEN_WIDTH-1:0] expected_len;

  // drops packets with a foreign header, 1 cycle
  rx_header_filter i_header_filter (
    .rx_axis_aclk    (rx_axis_aclk),
    .rx_axis_aresetn (rx_axis_aresetn),
    .cfg             (cfg),
    .mac_beat        (mac_beat),
    .filt_beat       (filt_beat),
    .expected_len    (expected_len)
  );

  // length verdict, strobe 1 cycle after the last filtered beat
  rx_length_checker i_length_checker (
    .rx_axis_aclk    (rx_axis_aclk),
    .rx_axis_aresetn (rx_axis_aresetn),
    .filt_beat       (filt_beat),
    .expected_len    (expected_len),
    .status          (status)
  );

  // removes an empty closing beat, 1 cycle
  rx_tail_trimmer i_tail_trimmer (
    .rx_axis_aclk    (rx_axis_aclk),
    .rx_axis_aresetn (rx_axis_aresetn),
    .filt_beat       (filt_beat),
    .udp_beat        (udp_beat)
  );

endmodule

`default_nettype wire

// ==== src/rx_tail_trimmer.sv ====
`default_nettype none

module rx_tail_trimmer
  import eth_rx_pkg::*;
(
  input  logic     rx_axis_aclk,
  input  logic     rx_axis_aresetn,
  input  rx_beat_t filt_beat,
  output rx_beat_t udp_beat
);

  // ----------------------------------------
  // holding stage
  // ----------------------------------------
  // one beat in hand, the incoming beat is the lookahead
  rx_beat_t held;

  always_ff @(posedge rx_axis_aclk) begin
    held.data <= filt_beat.data;
    held.keep <= filt_beat.keep;
    if (!rx_axis_aresetn) begin
      held.valid <= 1'b0;
      held.last  <= 1'b0;
    end else begin
      held.valid <= filt_beat.valid;
      held.last  <= filt_beat.valid && filt_beat.last;
    end
  end

  // ----------------------------------------
  // trim decision
  // ----------------------------------------
  logic held_empty;
  logic empty_tail_next;
  logic emit;

  assign held_empty = ~|held.keep;

  // beats of a packet are back to back, so the beat after held
  // is on filt_beat right now
  assign empty_tail_next = filt_beat.valid && filt_beat.last && ~|filt_beat.keep;

  // empty beats never leave
  assign emit = held.valid && !held_empty;

  always_comb begin
    udp_beat.valid = emit;
    udp_beat.data  = held.data;
    udp_beat.keep  = held.keep;
    // take over last from a trailing empty beat
    udp_beat.last  = emit && (held.last || empty_tail_next);
  end

endmodule

`default_nettype wire

// ==== src/rx_length_checker.sv ====
`default_nettype none

`include "eth_rx_defs.svh"

module rx_length_checker
  import eth_rx_pkg::*;
(
  input  logic                     rx_axis_aclk,
  input  logic                     rx_axis_aresetn,
  input  rx_beat_t                 filt_beat,
  input  logic [`RX_LEN_WIDTH-1:0] expected_len,
  output rx_status_t               status
);

  // ----------------------------------------
  // byte count
  // ----------------------------------------
  // running total of keep bits before the current beat
  logic [`RX_LEN_WIDTH-1:0] byte_count;
  logic [`RX_LEN_WIDTH-1:0] beat_bytes;
  logic [`RX_LEN_WIDTH-1:0] frame_bytes;
  logic [`RX_LEN_WIDTH-1:0] payload_bytes;
  logic                     pkt_done;

  assign beat_bytes  = `RX_LEN_WIDTH'($countones(filt_beat.keep));
  assign frame_bytes = byte_count + beat_bytes;

  // strip eth, ip and udp headers to compare with the udp payload size
  assign payload_bytes = frame_bytes - `RX_LEN_WIDTH'(`RX_HDR_BYTES);

  assign pkt_done = filt_beat.valid && filt_beat.last;

  always_ff @(posedge rx_axis_aclk) begin
    if (!rx_axis_aresetn) begin
      byte_count <= '0;
    end else if (filt_beat.valid) begin
      // counter restarts for the next packet
      if (filt_beat.last) begin
        byte_count <= '0;
      end else begin
        byte_count <= frame_bytes;
      end
    end
  end

  // ----------------------------------------
  // status strobe
  // ----------------------------------------
  always_ff @(posedge rx_axis_aclk) begin
    if (pkt_done) begin
      status.expected_len <= expected_len;
      status.measured_len <= payload_bytes;
      status.length_ok    <= (payload_bytes == expected_len);
    end
    if (!rx_axis_aresetn) begin
      status.valid <= 1'b0;
    end else begin
      // one pulse per accepted packet
      status.valid <= pkt_done;
    end
  end

endmodule

`default_nettype wire

// ==== src/rx_header_filter.sv ====
`default_nettype none

`include "eth_rx_defs.svh"

module rx_header_filter
  import eth_rx_pkg::*;
(
  input  logic                     rx_axis_aclk,
  input  logic                     rx_axis_aresetn,
  input  rx_config_t               cfg,
  input  rx_beat_t                 mac_beat,
  output rx_beat_t                 filt_beat,
  output logic [`RX_LEN_WIDTH-1:0] expected_len
);

  localparam int HDR_BITS = `RX_HDR_BYTES * 8;

  // byte offsets from the start of the frame
  localparam int OFS_DST_MAC  = 0;
  localparam int OFS_SRC_MAC  = 6;
  localparam int OFS_ETH_TYPE = 12;
  localparam int OFS_VER_IHL  = 14;
  localparam int OFS_PROTO    = 23;
  localparam int OFS_SRC_IP   = 26;
  localparam int OFS_DST_IP   = 30;
  localparam int OFS_SRC_PORT = 34;
  localparam int OFS_DST_PORT = 36;
  localparam int OFS_UDP_LEN  = 38;

  // ----------------------------------------
  // network order view of the header
  // ----------------------------------------
  // wire byte 0 ends up in the top byte, so fields read msb first
  logic [HDR_BITS-1:0] hdr_be;

  for (genvar i = 0; i < `RX_HDR_BYTES; i++) begin : g_hdr_swap
    assign hdr_be[HDR_BITS-8*(i+1) +: 8] = mac_beat.data[8*i +: 8];
  end

  logic [47:0] pkt_dst_mac;
  logic [47:0] pkt_src_mac;
  logic [15:0] pkt_eth_type;
  logic [3:0]  pkt_version;
  logic [7:0]  pkt_proto;
  logic [31:0] pkt_src_ip;
  logic [31:0] pkt_dst_ip;
  logic [15:0] pkt_src_port;
  logic [15:0] pkt_dst_port;
  logic [15:0] pkt_udp_len;

  assign pkt_dst_mac  = hdr_be[HDR_BITS-1-8*OFS_DST_MAC  -: 48];
  assign pkt_src_mac  = hdr_be[HDR_BITS-1-8*OFS_SRC_MAC  -: 48];
  assign pkt_eth_type = hdr_be[HDR_BITS-1-8*OFS_ETH_TYPE -: 16];
  // version is the upper nibble, ihl is not checked
  assign pkt_version  = hdr_be[HDR_BITS-1-8*OFS_VER_IHL  -: 4];
  assign pkt_proto    = hdr_be[HDR_BITS-1-8*OFS_PROTO    -: 8];
  assign pkt_src_ip   = hdr_be[HDR_BITS-1-8*OFS_SRC_IP   -: 32];
  assign pkt_dst_ip   = hdr_be[HDR_BITS-1-8*OFS_DST_IP   -: 32];
  assign pkt_src_port = hdr_be[HDR_BITS-1-8*OFS_SRC_PORT -: 16];
  assign pkt_dst_port = hdr_be[HDR_BITS-1-8*OFS_DST_PORT -: 16];
  assign pkt_udp_len  = hdr_be[HDR_BITS-1-8*OFS_UDP_LEN  -: 16];

  // loopback swap, frames come back with our addresses as source
  logic [47:0] cmp_dst_mac;
  logic [47:0] cmp_src_mac;
  logic [31:0] cmp_dst_ip;
  logic [15:0] cmp_dst_port;

  assign cmp_dst_mac  = cfg.loopback ? pkt_src_mac  : pkt_dst_mac;
  assign cmp_src_mac  = cfg.loopback ? pkt_dst_mac  : pkt_src_mac;
  assign cmp_dst_ip   = cfg.loopback ? pkt_src_ip   : pkt_dst_ip;
  assign cmp_dst_port = cfg.loopback ? pkt_src_port : pkt_dst_port;

  // ----------------------------------------
  // field checks
  // ----------------------------------------
  logic header_ok;

  assign header_ok = (cmp_dst_mac == cfg.dst_mac) &&
                     (cmp_src_mac == cfg.src_mac) &&
                     (pkt_eth_type == eth_type_ipv4) &&
                     (pkt_version == `RX_IP_VERSION) &&
                     (pkt_proto == ip_proto_udp) &&
                     (cmp_dst_ip == cfg.dst_ip) &&
                     (cmp_dst_port == cfg.dst_port);

  // verdict taken on the first beat, held through last
  beat_pos_e pos;
  logic      accept_held;
  logic      accept_now;

  assign accept_now = (pos == first_beat) ? header_ok : accept_held;

  always_ff @(posedge rx_axis_aclk) begin
    if (!rx_axis_aresetn) begin
      pos         <= first_beat;
      accept_held <= 1'b0;
    end else if (mac_beat.valid) begin
      if (pos == first_beat) begin
        accept_held <= header_ok;
      end
      pos <= mac_beat.last ? first_beat : in_packet;
    end
  end

  // registered output, payload passes unchanged
  always_ff @(posedge rx_axis_aclk) begin
    filt_beat.data <= mac_beat.data;
    filt_beat.keep <= mac_beat.keep;
    if (mac_beat.valid && pos == first_beat && header_ok) begin
      expected_len <= pkt_udp_len - `RX_LEN_WIDTH'(`RX_UDP_HDR_BYTES);
    end
    if (!rx_axis_aresetn) begin
      filt_beat.valid <= 1'b0;
      filt_beat.last  <= 1'b0;
    end else begin
      filt_beat.valid <= mac_beat.valid && accept_now;
      filt_beat.last  <= mac_beat.valid && accept_now && mac_beat.last;
    end
  end

endmodule

`default_nettype wire

// ==== src/eth_rx_pkg.sv ====
`default_nettype none

`include "eth_rx_defs.svh"

package eth_rx_pkg;

  // ----------------------------------------
  // streaming beat
  // ----------------------------------------
  // lane 0 of data and keep[0] carry the first wire byte
  typedef struct packed {
    logic                         valid;
    logic [`RX_DATA_WIDTH-1:0]    data;
    logic [`RX_DATA_BYTES-1:0]    keep;
    logic                         last;
  } rx_beat_t;

  // ----------------------------------------
  // runtime configuration
  // ----------------------------------------
  // held stable while a packet is in flight
  typedef struct packed {
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [31:0] dst_ip;
    logic [15:0] dst_port;
    // compare against swapped src/dst fields
    logic        loopback;
  } rx_config_t;

  // per-packet length result, valid is a single-cycle strobe
  typedef struct packed {
    logic                     valid;
    logic                     length_ok;
    logic [`RX_LEN_WIDTH-1:0] expected_len;
    logic [`RX_LEN_WIDTH-1:0] measured_len;
  } rx_status_t;

  // ----------------------------------------
  // enums
  // ----------------------------------------
  // where the filter stands inside a packet
  typedef enum logic {
    first_beat,
    in_packet
  } beat_pos_e;

  typedef enum logic [15:0] {
    eth_type_ipv4 = `RX_ETHTYPE_IPV4
  } eth_type_e;

  typedef enum logic [7:0] {
    ip_proto_udp = `RX_IP_PROTO_UDP
  } ip_proto_e;

endpackage

`default_nettype wire

// ==== src/eth_rx_defs.svh ====
`ifndef ETH_RX_DEFS_SVH
`define ETH_RX_DEFS_SVH

// beat geometry
`define RX_DATA_BYTES 64
`define RX_DATA_WIDTH 512

// ethernet + ipv4 (no options) + udp, all on the first beat
`define RX_HDR_BYTES 42
`define RX_UDP_HDR_BYTES 8

// byte counts and length fields
`define RX_LEN_WIDTH 16

// ----------------------------------------
// protocol codes
// ----------------------------------------
`define RX_ETHTYPE_IPV4 16'h0800
`define RX_IP_PROTO_UDP 8'd17
`define RX_IP_VERSION 4'd4

`endif
